// ==== filelist.f ====
+incdir+source
source/cpu_pkg.sv
source/fetcher.sv
source/decoder.sv
source/regs.sv
source/alu.sv
source/data_memory.sv
source/cpu.sv
test/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cpu -f filelist.f -o tb_cpu_sim &&
./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "run passed" && exit 0 ||
{ echo "run failed"; exit 1; }

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu;

    import cpu_pkg::*;

    logic    clk;
    logic    rstn;
    prog_t   prog;
    logic    retire;
    retire_t retire_info;
    logic    halted;

    logic [`INST_W-1:0] program_words [$];
    retire_t            got_q [$];
    retire_t            exp_q [$];
    integer             seed;
    integer             cycle_count;
    integer             cycle_limit;
    integer             errors;
    integer             tests_passed;
    integer             tests_failed;

    cpu dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .prog        (prog),
        .retire      (retire),
        .retire_info (retire_info),
        .halted      (halted)
    );

    always #4 clk = ~clk;

    // retire monitor sampling mid-cycle where retire is stable
    always @(negedge clk) begin
        if (retire) begin
            got_q.push_back(retire_info);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not halt within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [`INST_W-1:0] encode_reg_op(
        input opcode_t op, input logic [2:0] rd, input logic [2:0] rs1,
        input logic [2:0] rs2, input logic [2:0] f3);
        return {op, rd, rs1, rs2, f3};
    endfunction

    function automatic logic [`INST_W-1:0] encode_li(input logic [2:0] rd,
                                                     input logic [8:0] imm);
        return {OP_LI, rd, imm};
    endfunction

    function automatic logic [8:0] random_imm();
        integer r;
        r = $random(seed);
        return r[8:0];
    endfunction

    // reference model stepping the program by the ISA rules
    function automatic void build_expected();
        logic [`WORD_W-1:0]      rf [`REG_COUNT];
        logic [`WORD_W-1:0]      dm [`DMEM_DEPTH];
        logic [`ADDR_W-1:0]      pc;
        logic [`ADDR_W-1:0]      next_pc;
        logic [`IMEM_ADDR_W-1:0] idx;
        logic [`INST_W-1:0]      w;
        logic [`WORD_W-1:0]      a;
        logic [`WORD_W-1:0]      b;
        logic                    taken;
        logic                    done;
        retire_t                 e;
        for (int i = 0; i < `REG_COUNT; i++) begin
            rf[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            dm[i] = '0;
        end
        exp_q.delete();
        pc = `RESET_PC;
        done = 1'b0;
        for (int step = 0; step < `IMEM_DEPTH && !done; step++) begin
            idx = pc[`IMEM_ADDR_W:1];
            w = (idx < program_words.size()) ? program_words[idx] : {OP_HALT, 12'h000};
            a = rf[w[8:6]];
            b = rf[w[5:3]];
            e.pc = pc;
            e.wb_en = 1'b0;
            e.wb_addr = w[11:9];
            e.wb_data = '0;
            next_pc = pc + 16'd2;
            case (w[15:12])
                OP_ALU: begin
                    e.wb_en = 1'b1;
                    case (w[2:0])
                        ALU_ADD:  e.wb_data = a + b;
                        ALU_SUB:  e.wb_data = a - b;
                        ALU_AND:  e.wb_data = a & b;
                        ALU_OR:   e.wb_data = a | b;
                        ALU_XOR:  e.wb_data = a ^ b;
                        ALU_SLL:  e.wb_data = a << b[3:0];
                        ALU_SRL:  e.wb_data = a >> b[3:0];
                        default:  e.wb_data = {{(`WORD_W-1){1'b0}}, (a < b)};
                    endcase
                end
                OP_LI: begin
                    e.wb_en = 1'b1;
                    e.wb_data = {{(`WORD_W-`IMM_W){1'b0}}, w[8:0]};
                end
                OP_LOAD: begin
                    e.wb_en = 1'b1;
                    e.wb_data = dm[a[`DMEM_ADDR_W:1]];
                end
                OP_STORE: dm[a[`DMEM_ADDR_W:1]] = b;
                OP_BRANCH: begin
                    case (w[2:0])
                        BR_EQ:   taken = (a == b);
                        BR_NE:   taken = (a != b);
                        BR_LTU:  taken = (a < b);
                        BR_GEU:  taken = (a >= b);
                        default: taken = 1'b0;
                    endcase
                    if (taken) begin
                        next_pc = a;
                    end
                end
                OP_JAL: begin
                    e.wb_en = 1'b1;
                    e.wb_data = pc + 16'd2;
                    next_pc = a;
                end
                // halt and every unused code stop the program
                default: done = 1'b1;
            endcase
            if (e.wb_en) begin
                rf[e.wb_addr] = e.wb_data;
            end
            exp_q.push_back(e);
            pc = next_pc;
        end
    endfunction

    // holds rstn low for at least 16 cycles while the program is written
    task automatic load_program();
        int n;
        n = (program_words.size() > 16) ? program_words.size() : 16;
        @(negedge clk);
        rstn = 1'b0;
        cycle_count = 0;
        cycle_limit = 7 * exp_q.size() + n + 200;
        for (int i = 0; i < n; i++) begin
            prog.we = (i < program_words.size());
            prog.addr = i[`IMEM_ADDR_W-1:0];
            prog.data = (i < program_words.size()) ? program_words[i] : '0;
            @(negedge clk);
        end
        prog = '0;
        got_q.delete();
        rstn = 1'b1;
    endtask

    task automatic wait_for_halt();
        while (!halted) @(negedge clk);
        // halted must hold and nothing else may retire
        repeat (20) begin
            @(negedge clk);
            if (!halted) begin
                $display("[FAIL] %0t: halted dropped while no reset was applied", $time);
                errors++;
            end
        end
    endtask

    task automatic report_mismatch(input string field, input int idx,
                                   input logic [15:0] got, input logic [15:0] exp);
        $display("[FAIL] %0t: retire %0d %s got %h, expected %h",
                 $time, idx, field, got, exp);
        errors++;
    endtask

    task automatic compare_retires();
        if (got_q.size() != exp_q.size()) begin
            $display("[FAIL] %0t: %0d retires seen, expected %0d",
                     $time, got_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            if (got_q[i].pc !== exp_q[i].pc)
                report_mismatch("pc", i, got_q[i].pc, exp_q[i].pc);
            if (got_q[i].wb_en !== exp_q[i].wb_en)
                report_mismatch("wb_en", i, 16'(got_q[i].wb_en), 16'(exp_q[i].wb_en));
            if (exp_q[i].wb_en && got_q[i].wb_addr !== exp_q[i].wb_addr)
                report_mismatch("wb_addr", i, 16'(got_q[i].wb_addr), 16'(exp_q[i].wb_addr));
            if (exp_q[i].wb_en && got_q[i].wb_data !== exp_q[i].wb_data)
                report_mismatch("wb_data", i, got_q[i].wb_data, exp_q[i].wb_data);
        end
    endtask

    task automatic run_program(input string name);
        int errors_before;
        errors_before = errors;
        build_expected();
        load_program();
        wait_for_halt();
        compare_retires();
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: PASS, %0d retires", name, got_q.size());
        end else begin
            tests_failed++;
            $display("%s: FAIL, %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_alu_ops();
        program_words.delete();
        program_words.push_back(encode_li(3'd1, random_imm()));
        program_words.push_back(encode_li(3'd2, random_imm()));
        // rd wraps round to r0, r1 and r2 near the end
        for (int f = 0; f < 8; f++) begin
            program_words.push_back(encode_reg_op(OP_ALU, 3'd3 + f[2:0], 3'd1, 3'd2, f[2:0]));
        end
        program_words.push_back(encode_reg_op(OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0));
        run_program("li and alu ops");
    endtask

    task automatic test_store_load();
        program_words.delete();
        program_words.push_back(encode_li(3'd1, random_imm()));
        program_words.push_back(encode_li(3'd2, random_imm()));
        program_words.push_back(encode_reg_op(OP_STORE, 3'd0, 3'd1, 3'd2, 3'd0));
        program_words.push_back(encode_reg_op(OP_LOAD, 3'd3, 3'd1, 3'd0, 3'd0));
        program_words.push_back(encode_reg_op(OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0));
        run_program("store then load");
    endtask

    // each block branches over its last word when taken
    task automatic test_branches();
        logic [8:0] target;
        logic [2:0] cond;
        logic       taken;
        logic       bump;
        program_words.delete();
        for (int k = 0; k < 8; k++) begin
            target = 9'(8 * k + 8);
            cond = 3'(k / 2);
            taken = (k % 2 == 0);
            bump = (cond == BR_EQ || cond == BR_GEU) ? !taken : taken;
            program_words.push_back(encode_li(3'd1, target));
            program_words.push_back(encode_li(3'd2, target + 9'(bump)));
            program_words.push_back(encode_reg_op(OP_BRANCH, 3'd0, 3'd1, 3'd2, cond));
            program_words.push_back(encode_li(3'd7, 9'h1ff));
        end
        program_words.push_back(encode_reg_op(OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0));
        run_program("branches");
    endtask

    task automatic test_jal();
        program_words.delete();
        program_words.push_back(encode_li(3'd1, 9'd8));
        program_words.push_back(encode_reg_op(OP_JAL, 3'd2, 3'd1, 3'd0, 3'd0));
        program_words.push_back(encode_li(3'd3, 9'h055));
        program_words.push_back(encode_reg_op(OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0));
        program_words.push_back(encode_reg_op(OP_ALU, 3'd4, 3'd2, 3'd2, ALU_ADD));
        program_words.push_back(encode_reg_op(OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0));
        run_program("jump and link");
    endtask

    task automatic test_stop_word(input logic [`INST_W-1:0] stop_word, input string name);
        program_words.delete();
        program_words.push_back(encode_li(3'd1, random_imm()));
        program_words.push_back(stop_word);
        program_words.push_back(encode_li(3'd2, 9'h0aa));
        run_program(name);
    endtask

    task automatic test_reset_while_running();
        program_words.delete();
        program_words.push_back(encode_reg_op(OP_ALU, 3'd3, 3'd4, 3'd5, ALU_ADD));
        program_words.push_back(encode_li(3'd4, random_imm() | 9'd1));
        program_words.push_back(encode_li(3'd5, random_imm() | 9'd1));
        program_words.push_back(encode_reg_op(OP_ALU, 3'd6, 3'd4, 3'd5, ALU_ADD));
        program_words.push_back(encode_reg_op(OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0));
        build_expected();
        load_program();
        // r4 and r5 are written before the reset hits
        while (got_q.size() < 3) @(posedge clk);
        if (got_q[0].pc !== 16'h0000 || got_q[0].wb_data !== 16'h0000) begin
            $display("[FAIL] %0t: first run did not start at pc 0 with zero registers", $time);
            errors++;
        end
        run_program("reset while running");
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        prog = '0;
        seed = 28;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count = 0;
        cycle_limit = 1000;
        test_alu_ops();
        test_store_load();
        test_branches();
        test_jal();
        test_stop_word(encode_reg_op(OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0), "halt");
        test_stop_word({4'hf, 12'h000}, "unused opcode");
        test_reset_while_running();
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu (
    input  logic              clk,
    input  logic              rstn,
    input  cpu_pkg::prog_t    prog,
    output logic              retire,
    output cpu_pkg::retire_t  retire_info,
    output logic              halted
);

    import cpu_pkg::*;

    cpu_state_t             state;
    logic [`ADDR_W-1:0]     pc;
    logic [`ADDR_W-1:0]     pc_plus2;
    logic [`ADDR_W-1:0]     next_pc_q;
    logic [`ADDR_W-1:0]     exe_next_pc;
    logic                   run;

    logic                   fetch_order;
    logic                   fetched;
    logic [`INST_W-1:0]     inst;
    logic [`INST_W-1:0]     inst_q;

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`WORD_W-1:0]     rs1_data;
    logic [`WORD_W-1:0]     rs2_data;
    logic                   reg_we;
    decoded_t               dec;
    decoded_t               dec_q;

    logic [`WORD_W-1:0]     alu_result;
    logic                   branch_taken;

    logic                   is_mem;
    logic                   mem_req;
    logic                   mem_write;
    logic                   mem_done;
    logic [`WORD_W-1:0]     mem_rdata;

    retire_t                exe_wb;
    retire_t                wb_q;

    fetcher fetcher0 (
        .clk         (clk),
        .rstn        (rstn),
        .prog        (prog),
        .fetch_order (fetch_order),
        .pc          (pc),
        .inst        (inst),
        .fetched     (fetched)
    );

    decoder decoder0 (
        .inst     (inst_q),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec)
    );

    regs regs0 (
        .clk      (clk),
        .rstn     (rstn),
        .we       (reg_we),
        .wr_addr  (wb_q.wb_addr),
        .wr_data  (wb_q.wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu alu0 (
        .dec          (dec_q),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    data_memory data_memory0 (
        .clk       (clk),
        .rstn      (rstn),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .addr      (dec_q.rs1_val),
        .wdata     (dec_q.rs2_val),
        .rdata     (mem_rdata),
        .mem_done  (mem_done)
    );

    // run holds off the first fetch until reset has been released
    assign fetch_order = (state == S_FETCH) && run;
    assign pc_plus2    = pc + `PC_STEP;
    assign is_mem      = (dec_q.opcode == OP_LOAD) || (dec_q.opcode == OP_STORE);
    assign mem_req     = (state == S_EXECUTE) && is_mem;
    assign mem_write   = (dec_q.opcode == OP_STORE);
    assign reg_we      = (state == S_WRITE) && wb_q.wb_en;

    // write-back value and next pc per opcode
    always_comb begin
        exe_wb.pc      = pc;
        exe_wb.wb_en   = 1'b0;
        exe_wb.wb_addr = dec_q.rd;
        exe_wb.wb_data = alu_result;
        exe_next_pc    = pc_plus2;
        case (dec_q.opcode)
            OP_ALU: begin
                exe_wb.wb_en = 1'b1;
            end
            OP_LI: begin
                exe_wb.wb_en   = 1'b1;
                exe_wb.wb_data = {{(`WORD_W-`IMM_W){1'b0}}, dec_q.imm};
            end
            // data replaced once the memory answers
            OP_LOAD: begin
                exe_wb.wb_en = 1'b1;
            end
            OP_BRANCH: begin
                if (branch_taken) begin
                    exe_next_pc = dec_q.rs1_val;
                end
            end
            OP_JAL: begin
                exe_wb.wb_en   = 1'b1;
                exe_wb.wb_data = pc_plus2;
                exe_next_pc    = dec_q.rs1_val;
            end
            default: begin
            end
        endcase
    end

    // sequencer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= S_FETCH;
            pc     <= `RESET_PC;
            run    <= 1'b0;
            retire <= 1'b0;
            halted <= 1'b0;
        end else begin
            run    <= 1'b1;
            retire <= 1'b0;
            case (state)
                S_FETCH: begin
                    if (run) begin
                        state <= S_FETCH_WAIT;
                    end
                end
                S_FETCH_WAIT: begin
                    if (fetched) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: state <= S_EXECUTE;
                S_EXECUTE: state <= is_mem ? S_EXECUTE_WAIT : S_WRITE;
                S_EXECUTE_WAIT: begin
                    if (mem_done) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    pc     <= next_pc_q;
                    retire <= 1'b1;
                    state  <= (dec_q.opcode == OP_HALT) ? S_HALT : S_FETCH;
                end
                // halted rises after the halt retire pulse
                S_HALT: halted <= 1'b1;
                default: state <= S_FETCH;
            endcase
        end
    end

    // stage registers
    always_ff @(posedge clk) begin
        if ((state == S_FETCH_WAIT) && fetched) begin
            inst_q <= inst;
        end
        if (state == S_DECODE) begin
            dec_q <= dec;
        end
        if (state == S_EXECUTE) begin
            wb_q      <= exe_wb;
            next_pc_q <= exe_next_pc;
        end
        if ((state == S_EXECUTE_WAIT) && mem_done) begin
            wb_q.wb_data <= mem_rdata;
        end
        if (state == S_WRITE) begin
            retire_info <= wb_q;
        end
    end

    no_retire_when_halted: assert property (
        @(posedge clk) disable iff (!rstn)
        !(retire && halted)
    ) else $error("retire seen while halted");

    state_legal: assert property (
        @(posedge clk) disable iff (!rstn)
        state inside {S_FETCH, S_FETCH_WAIT, S_DECODE, S_EXECUTE,
                      S_EXECUTE_WAIT, S_WRITE, S_HALT}
    ) else $error("sequencer in an illegal state");

endmodule

// ==== source/data_memory.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module data_memory (
    input  logic               clk,
    input  logic               rstn,
    input  logic               mem_req,
    input  logic               mem_write,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`WORD_W-1:0] wdata,
    output logic [`WORD_W-1:0] rdata,
    output logic               mem_done
);

    logic [`WORD_W-1:0]      dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_W-1:0] idx;
    logic [`WORD_W-1:0]      rdata_d1;
    logic                    req_d1;

    // word index wraps at the array size
    assign idx = addr[`DMEM_ADDR_W:1];

    // access on the request cycle and data out one register later
    always_ff @(posedge clk) begin
        if (mem_req) begin
            if (mem_write) begin
                dmem[idx] <= wdata;
            end
            rdata_d1 <= dmem[idx];
        end
        rdata <= rdata_d1;
    end

    // two-stage done pipeline
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_d1   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            req_d1   <= mem_req;
            mem_done <= req_d1;
        end
    end

    // only one access in flight at a time
    one_access_in_flight: assert property (
        @(posedge clk) disable iff (!rstn)
        mem_req |-> !req_d1 && !mem_done
    ) else $error("mem_req while an earlier access is still in flight");

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
    input  cpu_pkg::decoded_t  dec,
    output logic [`WORD_W-1:0] result,
    output logic               branch_taken
);

    import cpu_pkg::*;

    logic [`WORD_W-1:0] a;
    logic [`WORD_W-1:0] b;

    assign a = dec.rs1_val;
    assign b = dec.rs2_val;

    // func3 picks the operation, shifts use b[3:0]
    always_comb begin
        case (alu_op_t'(dec.func3))
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << b[3:0];
            ALU_SRL:  result = a >> b[3:0];
            ALU_SLTU: result = {{(`WORD_W-1){1'b0}}, (a < b)};
            default:  result = a + b;
        endcase
    end

    // branch compare on the same operands
    always_comb begin
        case (branch_cond_t'(dec.func3))
            BR_EQ:   branch_taken = (a == b);
            BR_NE:   branch_taken = (a != b);
            BR_LTU:  branch_taken = (a < b);
            BR_GEU:  branch_taken = (a >= b);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== source/regs.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regs (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`WORD_W-1:0]     wr_data,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`WORD_W-1:0]     rs1_data,
    output logic [`WORD_W-1:0]     rs2_data
);

    logic [`WORD_W-1:0] rf [`REG_COUNT];

    // all registers clear, r0 included
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                rf[i] <= '0;
            end
        end else if (we) begin
            rf[wr_addr] <= wr_data;
        end
    end

    // asynchronous read ports
    assign rs1_data = rf[rs1_addr];
    assign rs2_data = rf[rs2_addr];

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decoder (
    input  logic [`INST_W-1:0]     inst,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`WORD_W-1:0]     rs1_data,
    input  logic [`WORD_W-1:0]     rs2_data,
    output cpu_pkg::decoded_t      dec
);

    import cpu_pkg::*;

    logic [`OPCODE_W-1:0]   op_bits;
    logic [`FUNC3_W-1:0]    func3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`IMM_W-1:0]      imm;
    opcode_t                opcode;

    // field slicing
    assign op_bits  = inst[15:12];
    assign rd       = inst[11:9];
    assign rs1_addr = inst[8:6];
    assign rs2_addr = inst[5:3];
    assign func3    = inst[2:0];

    // LI immediate overlaps rs1, rs2 and func3
    assign imm = inst[8:0];

    // unused opcode values fall back to halt
    always_comb begin
        case (op_bits)
            OP_ALU, OP_LI, OP_LOAD, OP_STORE,
            OP_BRANCH, OP_JAL, OP_HALT: begin
                opcode = opcode_t'(op_bits);
            end
            default: begin
                opcode = OP_HALT;
            end
        endcase
    end

    always_comb begin
        dec.opcode  = opcode;
        dec.func3   = func3;
        dec.rd      = rd;
        dec.rs1_val = rs1_data;
        dec.rs2_val = rs2_data;
        dec.imm     = imm;
    end

endmodule

// ==== source/fetcher.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetcher (
    input  logic               clk,
    input  logic               rstn,
    input  cpu_pkg::prog_t     prog,
    input  logic               fetch_order,
    input  logic [`ADDR_W-1:0] pc,
    output logic [`INST_W-1:0] inst,
    output logic               fetched
);

    logic [`INST_W-1:0]      imem [`IMEM_DEPTH];
    logic [`IMEM_ADDR_W-1:0] rd_idx;

    // pc is a byte address with two bytes per instruction
    assign rd_idx = pc[`IMEM_ADDR_W:1];

    // program load port and the registered read
    always_ff @(posedge clk) begin
        if (prog.we) begin
            imem[prog.addr] <= prog.data;
        end
        if (fetch_order) begin
            inst <= imem[rd_idx];
        end
    end

    // fetched follows the order by one cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fetched <= 1'b0;
        end else begin
            fetched <= fetch_order;
        end
    end

    // the program is only written while the core is held in reset
    prog_write_in_reset: assert property (
        @(posedge clk)
        prog.we |-> !rstn
    ) else $error("program write while rstn is high");

endmodule

// ==== source/cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

    // major opcode, inst[15:12]
    typedef enum logic [`OPCODE_W-1:0] {
        OP_ALU    = 4'h0,
        OP_LI     = 4'h1,
        OP_LOAD   = 4'h2,
        OP_STORE  = 4'h3,
        OP_BRANCH = 4'h4,
        OP_JAL    = 4'h5,
        OP_HALT   = 4'h6
    } opcode_t;

    // func3 under OP_ALU
    typedef enum logic [`FUNC3_W-1:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLL  = 3'd5,
        ALU_SRL  = 3'd6,
        ALU_SLTU = 3'd7
    } alu_op_t;

    // func3 under OP_BRANCH, codes 4..7 never taken
    typedef enum logic [`FUNC3_W-1:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LTU = 3'd2,
        BR_GEU = 3'd3
    } branch_cond_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXECUTE,
        S_EXECUTE_WAIT,
        S_WRITE,
        S_HALT
    } cpu_state_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [`FUNC3_W-1:0]    func3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`WORD_W-1:0]     rs1_val;
        logic [`WORD_W-1:0]     rs2_val;
        logic [`IMM_W-1:0]      imm;
    } decoded_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]     pc;
        logic                   wb_en;
        logic [`REG_ADDR_W-1:0] wb_addr;
        logic [`WORD_W-1:0]     wb_data;
    } retire_t;

    // program load, word indexed
    typedef struct packed {
        logic                    we;
        logic [`IMEM_ADDR_W-1:0] addr;
        logic [`INST_W-1:0]      data;
    } prog_t;

endpackage

// ==== source/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define WORD_W      16
`define INST_W      16
`define ADDR_W      16

// register file
`define REG_ADDR_W  3
`define REG_COUNT   8

// instruction fields
`define OPCODE_W    4
`define FUNC3_W     3
`define IMM_W       9

// memory sizes, in words
`define IMEM_DEPTH  256
`define IMEM_ADDR_W 8
`define DMEM_DEPTH  256
`define DMEM_ADDR_W 8

// pc after reset and the per-instruction step
`define RESET_PC    16'h0000
`define PC_STEP     16'd2

`endif
